//--- sources.f
+incdir+logic
logic/frame_pkg.sv
logic/mem_req_if.sv
logic/frame_fifo.sv
logic/mem_arbiter.sv
logic/frame_buffer.sv
logic/frame_writer.sv
logic/frame_reader.sv
logic/frame_channel_top.sv
bench/frame_channel_checker.sv
bench/frame_channel_tb.sv

//--- Bender.yml
package:
  name: frame_channel

sources:
  - include_dirs:
      - logic
    files:
      - logic/frame_pkg.sv
      - logic/mem_req_if.sv
      - logic/frame_fifo.sv
      - logic/mem_arbiter.sv
      - logic/frame_buffer.sv
      - logic/frame_writer.sv
      - logic/frame_reader.sv
      - logic/frame_channel_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/frame_channel_checker.sv
      - bench/frame_channel_tb.sv

//--- bench/frame_channel_tb.sv
/* Table-driven testbench of the frame channel. Each entry is fully drained before
   the next one starts, so its frame count can be checked on its own */
`include "frame_macros.svh"

module frame_channel_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import frame_pkg::*;

   localparam int HALF_PERIOD    = 20;
   localparam int DATA_PER_FRAME = `FRAME_CHUNKS - 1;
   localparam int NUM_ENTRIES    = 10;
   localparam int WORD_TIMEOUT   = 1000;
   localparam int DRAIN_TIMEOUT  = 4000;

   // One stimulus entry with the number of frames it must produce
   typedef struct packed {
      int unsigned burst_len;
      int unsigned gap;
      int unsigned hold;
      int unsigned frames;
   } entry_t;

   logic       clk;
   logic       rst_n;
   logic       in_valid;
   data_word_t in_data;
   logic       in_ready;
   logic       out_valid;
   data_word_t out_data;
   logic       out_last;
   logic       out_ready;

   entry_t     stim [NUM_ENTRIES];
   out_beat_t  expect_q [$];
   integer     seed;
   integer     ready_rnd;
   int         value_errors;
   int         other_errors;
   int         assert_fails;
   int         lasts_seen;
   logic       hold_ready;
   logic       saw_stall;
   logic       timed_out;

   frame_channel_top u_frame_channel_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_last  (out_last),
      .out_ready (out_ready)
   );

   // Port checks live inside the DUT scope
   bind frame_channel_top frame_channel_checker u_checker (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_last  (out_last),
      .out_ready (out_ready)
   );

   always #HALF_PERIOD clk = ~clk;

   // ========================================
   // Stimulus table
   // ========================================
   // Columns are burst length, gap cycles, out_ready hold cycles, frames expected
   task automatic load_stimulus();
      stim[0] = '{3, 60, 0, 1};
      stim[1] = '{7, 60, 0, 1};
      stim[2] = '{16, 60, 0, 3};
      stim[3] = '{5, 60, 0, 1};
      stim[4] = '{9, 60, 0, 2};
      stim[5] = '{14, 60, 0, 2};
      stim[6] = '{1, 60, 0, 1};
      // The ring and both FIFOs take about 58 words before in_ready can fall
      stim[7] = '{64, 80, 300, 10};
      stim[8] = '{16, 60, 0, 3};
      stim[9] = '{23, 70, 0, 4};
   endtask

   // Output ready is random unless an entry holds it low
   always @(posedge clk)
   begin
      ready_rnd = $random(seed);
      if (hold_ready)
         out_ready <= 1'b0;
      else
         out_ready <= (ready_rnd[1:0] != 2'b00);
   end

   // ========================================
   // Scoreboard
   // ========================================
   task automatic check_beat(input data_word_t data, input logic last);
      out_beat_t exp;
      if (expect_q.size() == 0)
      begin
         $display("Output word %h came out at %0t ns with no word pending", data, $time);
         other_errors++;
      end
      else
      begin
         exp = expect_q.pop_front();
         if (data !== exp.data)
         begin
            $display("[ERROR] %0t ns: out_data %h, expected %h", $time, data, exp.data);
            value_errors++;
         end
         if (last !== exp.last)
         begin
            $display("[ERROR] %0t ns: out_last %b on word %h, expected %b",
                     $time, last, data, exp.last);
            value_errors++;
         end
      end
      if (last)
         lasts_seen++;
   endtask

   // Values are sampled at the edge, before the DUT updates
   always @(posedge clk)
   begin
      if (rst_n && out_valid && out_ready)
         check_beat(out_data, out_last);
   end

   // ========================================
   // Drivers
   // ========================================
   // Every seventh word of a burst and its final word close a frame
   task automatic push_burst(input int unsigned len);
      int unsigned waited;
      out_beat_t   beat;
      for (int unsigned i = 1; (i <= len) && !timed_out; i++)
      begin
         beat.data = $random(seed);
         beat.last = ((i % DATA_PER_FRAME) == 0) || (i == len);
         in_valid <= 1'b1;
         in_data  <= beat.data;
         waited = 0;
         @(posedge clk);
         while (!in_ready && (waited < WORD_TIMEOUT))
         begin
            @(posedge clk);
            waited++;
         end
         if (!in_ready)
         begin
            $display("Timeout: in_ready stayed low for %0d cycles on word %0d", waited, i);
            other_errors++;
            timed_out = 1'b1;
         end
         else
            expect_q.push_back(beat);
      end
      in_valid <= 1'b0;
   endtask

   task automatic hold_output(input int unsigned cycles);
      hold_ready <= 1'b1;
      repeat (cycles) @(posedge clk);
      // A full ring behind a stalled output must be holding off the input
      saw_stall = in_valid && !in_ready;
      hold_ready <= 1'b0;
   endtask

   task automatic wait_drain(input int idx);
      int unsigned waited;
      waited = 0;
      while ((expect_q.size() != 0) && (waited < DRAIN_TIMEOUT))
      begin
         @(posedge clk);
         waited++;
      end
      if (expect_q.size() != 0)
      begin
         $display("Timeout: %0d words of entry %0d never came out", expect_q.size(), idx);
         other_errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic run_entry(input int idx);
      entry_t ent;
      ent = stim[idx];
      lasts_seen = 0;
      saw_stall  = 1'b0;
      if (ent.hold != 0)
         fork
            push_burst(ent.burst_len);
            hold_output(ent.hold);
         join
      else
         push_burst(ent.burst_len);
      if (!timed_out)
         wait_drain(idx);
      if (!timed_out)
      begin
         if (lasts_seen != ent.frames)
         begin
            $display("[ERROR] %0t ns: entry %0d gave %0d frames, expected %0d",
                     $time, idx, lasts_seen, ent.frames);
            value_errors++;
         end
         if ((ent.hold != 0) && !saw_stall)
         begin
            $display("in_ready was not low at the end of the out_ready hold in entry %0d",
                     idx);
            other_errors++;
         end
         repeat (ent.gap) @(posedge clk);
      end
   endtask

   // ========================================
   // Main sequence
   // ========================================
   initial
   begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      in_valid     = 1'b0;
      in_data      = '0;
      out_ready    = 1'b0;
      hold_ready   = 1'b0;
      seed         = 32'h5387ef07;
      value_errors = 0;
      other_errors = 0;
      lasts_seen   = 0;
      saw_stall    = 1'b0;
      timed_out    = 1'b0;
      load_stimulus();
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      for (int e = 0; (e < NUM_ENTRIES) && !timed_out; e++)
         run_entry(e);
      // Late or duplicated words would still show up here
      repeat (60) @(posedge clk);
      assert_fails = u_frame_channel_top.u_checker.fail_count;
      $display("Summary: %0d value errors, %0d other errors, %0d assertion failures",
               value_errors, other_errors, assert_fails);
      if ((value_errors == 0) && (other_errors == 0) && (assert_fails == 0))
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

//--- bench/frame_channel_checker.sv
/* Handshake checks on the frame channel ports, bound into the top level.
   The output hold check is off while rst_n is low */
module frame_channel_checker (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  in_ready,
   input logic                  out_valid,
   input frame_pkg::data_word_t out_data,
   input logic                  out_last,
   input logic                  out_ready
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;

   // An offered beat stays put until it is taken
   property out_held;
      @(posedge clk) disable iff (!rst_n)
         (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last));
   endproperty

   a_out_held: assert property (out_held)
   else
   begin
      $error("Output beat dropped or changed before out_ready");
      fail_count++;
   end

   // Nothing is offered right after reset
   a_out_idle: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
   else
   begin
      $error("out_valid high in the first cycle after reset");
      fail_count++;
   end

   // The input FIFO starts empty and accepts at once
   a_in_open: assert property (@(posedge clk) $rose(rst_n) |-> in_ready)
   else
   begin
      $error("in_ready low in the first cycle after reset");
      fail_count++;
   end

endmodule

//--- logic/frame_channel_top.sv
/* Frame channel from a valid/ready input stream to a valid/ready output stream
   with frame-end markers. Enabled straight out of reset */
module frame_channel_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  frame_pkg::data_word_t  in_data,
   output logic                   in_ready,
   output logic                   out_valid,
   output frame_pkg::data_word_t  out_data,
   output logic                   out_last,
   input  logic                   out_ready
);
   import frame_pkg::*;

   // One request path per client
   mem_req_if wr_if ();
   mem_req_if rd_if ();

   // Memory port between arbiter and buffer
   logic       mem_en;
   logic       mem_we;
   mem_addr_t  mem_addr;
   data_word_t mem_wdata;
   data_word_t mem_rdata;

   frame_writer u_frame_writer (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_data  (in_data),
      .in_ready (in_ready),
      .mem      (wr_if.client)
   );

   frame_reader u_frame_reader (
      .clk       (clk),
      .rst_n     (rst_n),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_last  (out_last),
      .out_ready (out_ready),
      .mem       (rd_if.client)
   );

   mem_arbiter u_mem_arbiter (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (wr_if.arbiter),
      .rd    (rd_if.arbiter),
      .en    (mem_en),
      .we    (mem_we),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (mem_rdata)
   );

   frame_buffer u_frame_buffer (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (mem_en),
      .we    (mem_we),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (mem_rdata)
   );

endmodule

//--- logic/frame_reader.sv
/* Drains finished frames in ring order and streams their words with a last
   marker on each frame's final word. Frees each header after draining it */
`include "frame_macros.svh"

module frame_reader (
   input  logic                   clk,
   input  logic                   rst_n,
   output logic                   out_valid,
   output frame_pkg::data_word_t  out_data,
   output logic                   out_last,
   input  logic                   out_ready,
   mem_req_if.client              mem
);
   import frame_pkg::*;

   localparam int CRED_W = $clog2(`FIFO_DEPTH + 1);

   typedef enum logic [1:0] {
      ST_POLL_HEADER,
      ST_WAIT_HEADER,
      ST_READ,
      ST_CLEAR_HEADER
   } state_t;

   state_t            state;
   frame_num_t        frame_num;
   chunk_idx_t        chunk_count;
   chunk_idx_t        issued;
   chunk_idx_t        received;
   // FIFO entries claimed by reads issued and not yet popped
   logic [CRED_W-1:0] credits;

   frame_header_t     rd_header;
   out_beat_t         push_beat;
   out_beat_t         pop_beat;
   logic              push_valid;
   logic              read_gnt;
   logic              pop_fire;
   logic              final_word;

   assign rd_header = frame_header_t'(mem.rdata);

   // ========================================
   // Output FIFO
   // ========================================
   assign push_valid     = (state == ST_READ) && mem.rvalid;
   assign final_word     = (received == chunk_idx_t'(chunk_count - 1'b1));
   assign push_beat.data = mem.rdata;
   assign push_beat.last = final_word;

   // Room is guaranteed by the credit count, so push_ready is not consulted
   frame_fifo #(
      .payload_t (out_beat_t),
      .DEPTH     (`FIFO_DEPTH)
   ) u_out_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (push_valid),
      .push_data  (push_beat),
      .push_ready (),
      .pop_valid  (out_valid),
      .pop_data   (pop_beat),
      .pop_ready  (out_ready)
   );

   assign out_data = pop_beat.data;
   assign out_last = pop_beat.last;
   assign pop_fire = out_valid && out_ready;

   // ========================================
   // Memory request
   // ========================================
   assign mem.req = (state == ST_POLL_HEADER) || (state == ST_CLEAR_HEADER) ||
                    ((state == ST_READ) && (issued != chunk_count) &&
                     (credits != CRED_W'(`FIFO_DEPTH)));
   assign mem.we    = (state == ST_CLEAR_HEADER);
   assign mem.addr  = (state == ST_READ) ? make_addr(frame_num, issued + 1'b1)
                                         : make_addr(frame_num, '0);
   // A zero header marks the frame free again
   assign mem.wdata = '0;
   assign read_gnt  = (state == ST_READ) && mem.gnt;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= ST_POLL_HEADER;
         frame_num   <= '0;
         chunk_count <= '0;
         issued      <= '0;
         received    <= '0;
         credits     <= '0;
      end
      else
      begin
         if (read_gnt && !pop_fire)
            credits <= credits + 1'b1;
         else if (pop_fire && !read_gnt)
            credits <= credits - 1'b1;
         case (state)
            ST_POLL_HEADER:
               if (mem.gnt)
                  state <= ST_WAIT_HEADER;
            ST_WAIT_HEADER:
               if (mem.rvalid)
               begin
                  // The writer never publishes an empty frame
                  if (rd_header.in_use)
                     state <= ST_READ;
                  else
                     state <= ST_POLL_HEADER;
                  chunk_count <= rd_header.chunk_count;
                  issued      <= '0;
                  received    <= '0;
               end
            ST_READ:
            begin
               if (read_gnt)
                  issued <= issued + 1'b1;
               if (mem.rvalid)
               begin
                  received <= received + 1'b1;
                  if (final_word)
                     state <= ST_CLEAR_HEADER;
               end
            end
            ST_CLEAR_HEADER:
               if (mem.gnt)
               begin
                  state <= ST_POLL_HEADER;
                  if (frame_num == frame_num_t'(`FRAME_COUNT - 1))
                     frame_num <= '0;
                  else
                     frame_num <= frame_num + 1'b1;
               end
            default:
               state <= ST_POLL_HEADER;
         endcase
      end
   end

endmodule

//--- logic/frame_writer.sv
/* Packs the input stream into ring frames and publishes each with its header.
   A partial frame closes after IDLE_LIMIT empty cycles with data written */
`include "frame_macros.svh"

module frame_writer (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  frame_pkg::data_word_t  in_data,
   output logic                   in_ready,
   mem_req_if.client              mem
);
   import frame_pkg::*;

   localparam int IDLE_W = $clog2(`IDLE_LIMIT + 1);

   typedef enum logic [1:0] {
      ST_POLL_HEADER,
      ST_WAIT_HEADER,
      ST_WRITE,
      ST_WRITE_CONTROL
   } state_t;

   state_t            state;
   state_t            next_state;
   frame_num_t        frame_num;
   // Data words written into the current frame
   chunk_idx_t        chunk_count;
   logic [IDLE_W-1:0] idle_count;

   logic              fifo_valid;
   data_word_t        fifo_data;
   frame_header_t     rd_header;
   frame_header_t     wr_header;
   logic              frame_full;
   logic              frame_done;
   logic              data_write;

   // ========================================
   // Input FIFO
   // ========================================
   frame_fifo #(
      .payload_t (data_word_t),
      .DEPTH     (`FIFO_DEPTH)
   ) u_in_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (in_valid),
      .push_data  (in_data),
      .push_ready (in_ready),
      .pop_valid  (fifo_valid),
      .pop_data   (fifo_data),
      .pop_ready  (data_write)
   );

   // Header as it comes back from the poll read
   assign rd_header = frame_header_t'(mem.rdata);

   // Header written to close the frame
   always_comb
   begin
      wr_header             = '0;
      wr_header.in_use      = 1'b1;
      wr_header.chunk_count = chunk_count;
   end

   assign frame_full = (chunk_count == chunk_idx_t'(`FRAME_CHUNKS - 1));
   assign frame_done = frame_full ||
                       ((idle_count == IDLE_W'(`IDLE_LIMIT)) && (chunk_count != '0));

   // Each granted data write takes one FIFO word
   assign data_write = (state == ST_WRITE) && mem.gnt;

   // ========================================
   // Memory request
   // ========================================
   assign mem.req = (state == ST_POLL_HEADER) ||
                    ((state == ST_WRITE) && fifo_valid && !frame_done) ||
                    (state == ST_WRITE_CONTROL);
   assign mem.we  = (state == ST_WRITE) || (state == ST_WRITE_CONTROL);
   // Data goes one past the header word
   assign mem.addr  = (state == ST_WRITE) ? make_addr(frame_num, chunk_count + 1'b1)
                                          : make_addr(frame_num, '0);
   assign mem.wdata = (state == ST_WRITE) ? fifo_data : data_word_t'(wr_header);

   always_comb
   begin
      next_state = state;
      case (state)
         ST_POLL_HEADER:
            if (mem.gnt)
               next_state = ST_WAIT_HEADER;
         ST_WAIT_HEADER:
            // A frame not yet drained is polled again
            if (mem.rvalid)
               next_state = rd_header.in_use ? ST_POLL_HEADER : ST_WRITE;
         ST_WRITE:
            if (frame_done)
               next_state = ST_WRITE_CONTROL;
         ST_WRITE_CONTROL:
            if (mem.gnt)
               next_state = ST_POLL_HEADER;
         default:
            next_state = ST_POLL_HEADER;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= ST_POLL_HEADER;
         frame_num   <= '0;
         chunk_count <= '0;
         idle_count  <= '0;
      end
      else
      begin
         state <= next_state;
         if (state == ST_POLL_HEADER)
            chunk_count <= '0;
         else if (data_write)
            chunk_count <= chunk_count + 1'b1;
         // Only empty cycles inside a frame count toward the idle limit
         if (fifo_valid || (state != ST_WRITE))
            idle_count <= '0;
         else if (idle_count != IDLE_W'(`IDLE_LIMIT))
            idle_count <= idle_count + 1'b1;
         // Next frame in the ring once the header is out
         if ((state == ST_WRITE_CONTROL) && mem.gnt)
         begin
            if (frame_num == frame_num_t'(`FRAME_COUNT - 1))
               frame_num <= '0;
            else
               frame_num <= frame_num + 1'b1;
         end
      end
   end

endmodule

//--- logic/frame_buffer.sv
/* Single-port frame memory with one-cycle read latency. All words clear on
   reset, so every header starts out free */
`include "frame_macros.svh"

module frame_buffer (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   en,
   input  logic                   we,
   input  frame_pkg::mem_addr_t   addr,
   input  frame_pkg::data_word_t  wdata,
   output frame_pkg::data_word_t  rdata
);
   import frame_pkg::*;

   localparam int WORDS = `FRAME_COUNT * `FRAME_CHUNKS;

   // ========================================
   // Storage
   // ========================================
   data_word_t words [WORDS];

   // Frames sit back to back from address 0
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < WORDS; i++)
            words[i] <= '0;
         rdata <= '0;
      end
      else if (en)
      begin
         if (we)
            words[addr] <= wdata;
         else
            rdata <= words[addr];
      end
   end

endmodule

//--- logic/mem_arbiter.sv
/* Round-robin arbiter of two clients onto the single-port frame buffer.
   Grants in the request cycle; with both requesting, the grants alternate */
module mem_arbiter (
   input  logic                   clk,
   input  logic                   rst_n,
   mem_req_if.arbiter             wr,
   mem_req_if.arbiter             rd,
   output logic                   en,
   output logic                   we,
   output frame_pkg::mem_addr_t   addr,
   output frame_pkg::data_word_t  wdata,
   input  frame_pkg::data_word_t  rdata
);
   import frame_pkg::*;

   // High when the reader wins a tie
   logic prio_rd;
   logic wr_gnt;
   logic rd_gnt;
   // A read was granted last cycle, and to which client
   logic read_pend;
   logic read_to_rd;

   assign wr_gnt = wr.req && (!rd.req || !prio_rd);
   assign rd_gnt = rd.req && !wr_gnt;

   assign wr.gnt = wr_gnt;
   assign rd.gnt = rd_gnt;

   // The granted client drives the memory port
   assign en    = wr_gnt || rd_gnt;
   assign we    = wr_gnt ? wr.we    : rd.we;
   assign addr  = wr_gnt ? wr.addr  : rd.addr;
   assign wdata = wr_gnt ? wr.wdata : rd.wdata;

   // Read data goes to both; only the owner sees rvalid
   assign wr.rdata  = rdata;
   assign rd.rdata  = rdata;
   assign wr.rvalid = read_pend && !read_to_rd;
   assign rd.rvalid = read_pend && read_to_rd;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         prio_rd    <= 1'b0;
         read_pend  <= 1'b0;
         read_to_rd <= 1'b0;
      end
      else
      begin
         // The client just served drops to low priority
         if (wr_gnt)
            prio_rd <= 1'b1;
         else if (rd_gnt)
            prio_rd <= 1'b0;
         read_pend  <= en && !we;
         read_to_rd <= rd_gnt;
      end
   end

endmodule

//--- logic/frame_fifo.sv
/* Circular-buffer FIFO with valid/ready on both sides. DEPTH must be a power
   of two; a pushed entry shows at the pop side on the next cycle */
`include "frame_macros.svh"

module frame_fifo #(
   parameter type payload_t = frame_pkg::data_word_t,
   parameter int  DEPTH     = `FIFO_DEPTH
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push_valid,
   input  payload_t push_data,
   output logic     push_ready,
   output logic     pop_valid,
   output payload_t pop_data,
   input  logic     pop_ready
);

   localparam int PTR_W = $clog2(DEPTH);

   payload_t             store [DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [PTR_W:0]       count;
   logic                 push_fire;
   logic                 pop_fire;

   assign push_ready = (count != (PTR_W+1)'(DEPTH));
   assign pop_valid  = (count != '0);
   assign pop_data   = store[rd_ptr];

   assign push_fire = push_valid && push_ready;
   assign pop_fire  = pop_valid && pop_ready;

   // Pointers wrap on their own since DEPTH is a power of two
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push_fire)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_fire)
            rd_ptr <= rd_ptr + 1'b1;
         // Occupancy moves only when one side fires alone
         if (push_fire && !pop_fire)
            count <= count + 1'b1;
         else if (pop_fire && !push_fire)
            count <= count - 1'b1;
      end
   end

   // Payload storage
   always_ff @(posedge clk)
   begin
      if (push_fire)
         store[wr_ptr] <= push_data;
   end

endmodule

//--- logic/mem_req_if.sv
/* Request path from one client to the frame buffer arbiter. A request holds
   its fields until gnt, and read data returns with rvalid one cycle after gnt */
interface mem_req_if;
   import frame_pkg::*;

   // Driven by the client
   logic       req;
   logic       we;
   mem_addr_t  addr;
   data_word_t wdata;

   // Driven by the arbiter
   logic       gnt;
   logic       rvalid;
   data_word_t rdata;

   modport client (
      output req, we, addr, wdata,
      input  gnt, rvalid, rdata
   );

   modport arbiter (
      input  req, we, addr, wdata,
      output gnt, rvalid, rdata
   );

endinterface

//--- logic/frame_pkg.sv
/* Types shared by the frame channel. The ring base is fixed at address 0 */
`include "frame_macros.svh"

package frame_pkg;

   // ========================================
   // Widths derived from the sizes
   // ========================================
   localparam int FRAME_W = $clog2(`FRAME_COUNT);
   localparam int CHUNK_W = $clog2(`FRAME_CHUNKS);

   // One data word, also one frame buffer word
   typedef logic [`FRAME_DATA_W-1:0] data_word_t;

   // A frame number in the ring and a word index inside a frame
   typedef logic [FRAME_W-1:0] frame_num_t;
   typedef logic [CHUNK_W-1:0] chunk_idx_t;

   // A word address is the frame number above the chunk index
   typedef logic [FRAME_W+CHUNK_W-1:0] mem_addr_t;

   // Word 0 of every frame; in_use is set by the writer and cleared by the reader
   typedef struct packed {
      logic                              in_use;
      logic [`FRAME_DATA_W-CHUNK_W-2:0] spare;
      chunk_idx_t                        chunk_count;
   } frame_header_t;

   // One beat on the output stream
   typedef struct packed {
      data_word_t data;
      logic       last;
   } out_beat_t;

   // Word address of chunk c in frame f
   function automatic mem_addr_t make_addr(frame_num_t f, chunk_idx_t c);
      return {f, c};
   endfunction

endpackage

//--- logic/frame_macros.svh
/* Sizes of the frame channel. FRAME_COUNT and FIFO_DEPTH must be powers of two,
   and FRAME_CHUNKS must fit the header chunk count field */
`ifndef FRAME_MACROS_SVH
`define FRAME_MACROS_SVH

// Width of one data word and of one frame buffer word
`define FRAME_DATA_W 32

// Frames in the ring
`define FRAME_COUNT 4

// Words per frame, header word included
`define FRAME_CHUNKS 8

// Empty-FIFO cycles that close a partly filled frame
`define IDLE_LIMIT 15

// Depth of the writer and reader FIFOs
`define FIFO_DEPTH 16

`endif
